//--- verilog/rv_csr_pkg.sv
package rv_csr_pkg;

  // data path width
  localparam int xlen = 32;

  //////////////////////////////
  // machine csr addresses
  //////////////////////////////

  localparam logic [11:0] csr_addr_mstatus   = 12'h300;
  localparam logic [11:0] csr_addr_mtvec     = 12'h305;
  localparam logic [11:0] csr_addr_mepc      = 12'h341;
  localparam logic [11:0] csr_addr_mcause    = 12'h342;
  localparam logic [11:0] csr_addr_mvendorid = 12'hF11;
  localparam logic [11:0] csr_addr_marchid   = 12'hF12;

  //////////////////////////////
  // reset and identity values
  //////////////////////////////

  // mpp = machine mode
  localparam logic [xlen-1:0] mstatus_reset = 32'h0000_1800;

  // read-only ids
  localparam logic [xlen-1:0] mvendorid_value = 32'h7973_7978;
  localparam logic [xlen-1:0] marchid_value   = 32'h017D_9F58;

  //////////////////////////////
  // mcause exception codes
  //////////////////////////////

  // synchronous exceptions only, interrupt bit always clear
  localparam logic [xlen-1:0] cause_inst_misaligned  = 32'd0;
  localparam logic [xlen-1:0] cause_load_misaligned  = 32'd4;
  localparam logic [xlen-1:0] cause_store_misaligned = 32'd6;
  localparam logic [xlen-1:0] cause_ecall_m          = 32'd11;

  // ordering of the four codes above is numeric, not priority;
  // priority lives in the trap logic

endpackage

//--- verilog/commit_pkg.sv
package commit_pkg;

  //////////////////////////////
  // register index
  //////////////////////////////

  // wide enough for rv32i, rv32e uses the low four bits
  localparam int gpr_index_width = 5;

  //////////////////////////////
  // redirect kinds
  //////////////////////////////

  // what the commit stage does to the front end this cycle
  typedef enum logic [1:0] {
    redirect_none  = 2'd0, // plain retire or idle
    redirect_trap  = 2'd1, // exception, fetch from mtvec
    redirect_mret  = 2'd2, // return, fetch from mepc
    redirect_flush = 2'd3  // fence_i or mispredict
  } redirect_kind_t;

  // every kind except redirect_none costs one flush cycle;
  // only redirect_trap touches the csr state

endpackage

//--- verilog/gpr_file.sv
`timescale 1ns/1ps

module gpr_file #(
  parameter int gpr_count = 16
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [commit_pkg::gpr_index_width-1:0] rs1,
  input  logic [commit_pkg::gpr_index_width-1:0] rs2,
  input  logic [commit_pkg::gpr_index_width-1:0] rd,
  input  logic                                commit,
  input  logic [rv_csr_pkg::xlen-1:0]         wdata,
  output logic [rv_csr_pkg::xlen-1:0]         src1,
  output logic [rv_csr_pkg::xlen-1:0]         src2
);

  import rv_csr_pkg::*;

  // low bits only, so indices wrap modulo gpr_count
  localparam int idx_width = $clog2(gpr_count);

  logic [xlen-1:0]      regs [gpr_count];
  logic [idx_width-1:0] rs1_idx;
  logic [idx_width-1:0] rs2_idx;
  logic [idx_width-1:0] rd_idx;

  assign rs1_idx = rs1[idx_width-1:0];
  assign rs2_idx = rs2[idx_width-1:0];
  assign rd_idx  = rd[idx_width-1:0];

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < gpr_count; i++) begin
        regs[i] <= '0;
      end
    end else if (commit && rd_idx != '0) begin // x0 never written
      regs[rd_idx] <= wdata;
    end
  end

  //////////////////////////////
  // read ports, no bypass
  //////////////////////////////

  assign src1 = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign src2 = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- verilog/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [11:0]                 csr_s,
  input  logic [11:0]                 csr_d,
  input  logic                        commit,
  input  logic [rv_csr_pkg::xlen-1:0] csr_wdata,
  input  logic                        trap_take,
  input  logic [rv_csr_pkg::xlen-1:0] trap_cause,
  input  logic [rv_csr_pkg::xlen-1:0] trap_pc,
  output logic [rv_csr_pkg::xlen-1:0] csr_src,
  output logic [rv_csr_pkg::xlen-1:0] mtvec_value,
  output logic [rv_csr_pkg::xlen-1:0] mepc_value
);

  import rv_csr_pkg::*;

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  //////////////////////////////
  // software writes
  //////////////////////////////

  // mstatus is a plain word, no field semantics
  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= mstatus_reset;
      mtvec   <= '0;
    end else if (commit) begin
      if (csr_d == csr_addr_mstatus) begin
        mstatus <= csr_wdata;
      end
      if (csr_d == csr_addr_mtvec) begin
        mtvec <= csr_wdata;
      end
    end
  end

  //////////////////////////////
  // trap record
  //////////////////////////////

  // mepc shared between sw write and trap entry
  always_ff @(posedge clock) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
    end else if (trap_take) begin
      mepc   <= trap_pc;
      mcause <= trap_cause;
    end else if (commit && csr_d == csr_addr_mepc) begin
      mepc <= csr_wdata;
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    case (csr_s)
      csr_addr_mstatus:   csr_src = mstatus;
      csr_addr_mtvec:     csr_src = mtvec;
      csr_addr_mepc:      csr_src = mepc;
      csr_addr_mcause:    csr_src = mcause;
      csr_addr_mvendorid: csr_src = mvendorid_value;
      csr_addr_marchid:   csr_src = marchid_value;
      default:            csr_src = '0; // unimplemented reads as zero
    endcase
  end

  // trap vector and return address for the redirect logic
  assign mtvec_value = mtvec;
  assign mepc_value  = mepc;

endmodule

//--- verilog/trap_redirect.sv
`timescale 1ns/1ps

module trap_redirect (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        ls_valid,
  input  logic                        inst_addr_misaligned,
  input  logic                        ecall,
  input  logic                        load_addr_misaligned,
  input  logic                        store_addr_misaligned,
  input  logic                        mret,
  input  logic                        fence_i,
  input  logic                        wrong_prediction,
  input  logic                        wen,
  input  logic                        csr_wen,
  input  logic [rv_csr_pkg::xlen-1:0] lsu_pc,
  input  logic [rv_csr_pkg::xlen-1:0] exu_npc,
  input  logic [rv_csr_pkg::xlen-1:0] mtvec_value,
  input  logic [rv_csr_pkg::xlen-1:0] mepc_value,
  output logic                        gpr_commit,
  output logic                        csr_commit,
  output logic                        trap_take,
  output logic [rv_csr_pkg::xlen-1:0] trap_cause,
  output logic [rv_csr_pkg::xlen-1:0] trap_pc,
  output logic                        clear_pipeline,
  output logic                        clear_cache,
  output logic                        npc_valid,
  output logic [rv_csr_pkg::xlen-1:0] npc
);

  import rv_csr_pkg::*;
  import commit_pkg::*;

  logic           exception;
  redirect_kind_t kind;

  assign exception = inst_addr_misaligned | ecall | load_addr_misaligned |
                     store_addr_misaligned;

  // fixed priority, lowest code is not the winner
  always_comb begin
    if (inst_addr_misaligned) begin
      trap_cause = cause_inst_misaligned;
    end else if (ecall) begin
      trap_cause = cause_ecall_m;
    end else if (load_addr_misaligned) begin
      trap_cause = cause_load_misaligned;
    end else begin
      trap_cause = cause_store_misaligned;
    end
  end

  assign trap_pc = lsu_pc;

  //////////////////////////////
  // commit gating
  //////////////////////////////

  assign trap_take  = exception & ~clear_pipeline;
  assign gpr_commit = wen & ~clear_pipeline;
  assign csr_commit = csr_wen & ~clear_pipeline & ~exception; // trap owns mepc

  // inputs are dead during the flush cycle
  always_comb begin
    if (clear_pipeline)                 kind = redirect_none;
    else if (exception)                 kind = redirect_trap;
    else if (mret)                      kind = redirect_mret;
    else if (fence_i | wrong_prediction) kind = redirect_flush;
    else                                kind = redirect_none;
  end

  //////////////////////////////
  // registered redirect
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      clear_pipeline <= 1'b0;
      clear_cache    <= 1'b0;
      npc_valid      <= 1'b0;
      npc            <= '0;
    end else if (clear_pipeline) begin
      clear_pipeline <= 1'b0; // exactly one flush cycle
      clear_cache    <= 1'b0;
      npc_valid      <= 1'b0;
    end else begin
      clear_pipeline <= (kind != redirect_none);
      clear_cache    <= fence_i & ~exception;
      npc_valid      <= ls_valid;
      case (kind)
        redirect_trap: npc <= mtvec_value;
        redirect_mret: npc <= mepc_value;
        default:       npc <= exu_npc; // mispredict lands here too
      endcase
    end
  end

endmodule

//--- verilog/commit_unit.sv
`timescale 1ns/1ps

module commit_unit #(
  parameter int gpr_count = 16
) (
  input  logic                                   clock,
  input  logic                                   reset,

  // register reads
  input  logic [commit_pkg::gpr_index_width-1:0] rs1,
  input  logic [commit_pkg::gpr_index_width-1:0] rs2,
  input  logic [11:0]                            csr_s,
  output logic [rv_csr_pkg::xlen-1:0]            src1,
  output logic [rv_csr_pkg::xlen-1:0]            src2,
  output logic [rv_csr_pkg::xlen-1:0]            csr_src,

  // write ports
  input  logic [commit_pkg::gpr_index_width-1:0] rd,
  input  logic                                   wen,
  input  logic [rv_csr_pkg::xlen-1:0]            wdata,
  input  logic [11:0]                            csr_d,
  input  logic                                   csr_wen,
  input  logic [rv_csr_pkg::xlen-1:0]            csr_wdata,

  // retire events
  input  logic                                   ls_valid,
  input  logic                                   inst_addr_misaligned,
  input  logic                                   ecall,
  input  logic                                   load_addr_misaligned,
  input  logic                                   store_addr_misaligned,
  input  logic                                   mret,
  input  logic                                   fence_i,
  input  logic                                   wrong_prediction,
  input  logic [rv_csr_pkg::xlen-1:0]            lsu_pc,
  input  logic [rv_csr_pkg::xlen-1:0]            exu_npc,

  // front end redirect
  output logic                                   clear_pipeline,
  output logic                                   clear_cache,
  output logic [rv_csr_pkg::xlen-1:0]            npc,
  output logic                                   npc_valid
);

  import rv_csr_pkg::*;

  logic            gpr_commit;
  logic            csr_commit;
  logic            trap_take;
  logic [xlen-1:0] trap_cause;
  logic [xlen-1:0] trap_pc;
  logic [xlen-1:0] mtvec_value;
  logic [xlen-1:0] mepc_value;

  //////////////////////////////
  // architectural state
  //////////////////////////////

  gpr_file #(
    .gpr_count (gpr_count)
  ) gpr_file_inst (
    .clock  (clock),
    .reset  (reset),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .commit (gpr_commit),
    .wdata  (wdata),
    .src1   (src1),
    .src2   (src2)
  );

  csr_file csr_file_inst (
    .clock       (clock),
    .reset       (reset),
    .csr_s       (csr_s),
    .csr_d       (csr_d),
    .commit      (csr_commit),
    .csr_wdata   (csr_wdata),
    .trap_take   (trap_take),
    .trap_cause  (trap_cause),
    .trap_pc     (trap_pc),
    .csr_src     (csr_src),
    .mtvec_value (mtvec_value),
    .mepc_value  (mepc_value)
  );

  //////////////////////////////
  // traps and redirects
  //////////////////////////////

  trap_redirect trap_redirect_inst (
    .clock                 (clock),
    .reset                 (reset),
    .ls_valid              (ls_valid),
    .inst_addr_misaligned  (inst_addr_misaligned),
    .ecall                 (ecall),
    .load_addr_misaligned  (load_addr_misaligned),
    .store_addr_misaligned (store_addr_misaligned),
    .mret                  (mret),
    .fence_i               (fence_i),
    .wrong_prediction      (wrong_prediction),
    .wen                   (wen),
    .csr_wen               (csr_wen),
    .lsu_pc                (lsu_pc),
    .exu_npc               (exu_npc),
    .mtvec_value           (mtvec_value),
    .mepc_value            (mepc_value),
    .gpr_commit            (gpr_commit),
    .csr_commit            (csr_commit),
    .trap_take             (trap_take),
    .trap_cause            (trap_cause),
    .trap_pc               (trap_pc),
    .clear_pipeline        (clear_pipeline),
    .clear_cache           (clear_cache),
    .npc_valid             (npc_valid),
    .npc                   (npc)
  );

endmodule

//--- sim/commit_unit_tb.sv
`timescale 1ns/1ps

module commit_unit_tb;

  import rv_csr_pkg::*;
  import commit_pkg::*;

  localparam int gpr_count  = 16;
  // reset, reads, gpr, csr, trap, redirect, flush, tail
  localparam int step_count = 4 + 32 + 150 + 15 + 3 * 15 + 60 + 3 * 10 + 2;

  logic                       clock;
  logic                       reset;
  logic [gpr_index_width-1:0] rs1, rs2, rd;
  logic [11:0]                csr_s, csr_d;
  logic                       wen, csr_wen, ls_valid;
  logic                       inst_addr_misaligned, ecall, load_addr_misaligned;
  logic                       store_addr_misaligned, mret, fence_i, wrong_prediction;
  logic [xlen-1:0]            wdata, csr_wdata, lsu_pc, exu_npc;
  logic [xlen-1:0]            src1, src2, csr_src, npc;
  logic                       clear_pipeline, clear_cache, npc_valid;

  // reference model
  logic [xlen-1:0] m_regs [gpr_count];
  logic [xlen-1:0] m_mstatus, m_mtvec, m_mepc, m_mcause, m_npc;
  logic            m_flush, m_cache, m_npc_valid;

  string       test_name;
  int          error_count;
  int          check_count;
  logic [11:0] csr_list [7] = '{csr_addr_mstatus, csr_addr_mtvec, csr_addr_mepc,
                                csr_addr_mcause, csr_addr_mvendorid, csr_addr_marchid,
                                12'h7C0};

  commit_unit #(.gpr_count(gpr_count)) commit_unit_inst (.*);

  initial clock = 1'b0;
  always #5 clock = ~clock;

  //////////////////////////////
  // model
  //////////////////////////////

  function automatic logic [xlen-1:0] model_gpr(input logic [gpr_index_width-1:0] idx);
    int r;
    r = idx % gpr_count;
    return (r == 0) ? '0 : m_regs[r];
  endfunction

  function automatic logic [xlen-1:0] model_csr(input logic [11:0] addr);
    case (addr)
      csr_addr_mstatus:   return m_mstatus;
      csr_addr_mtvec:     return m_mtvec;
      csr_addr_mepc:      return m_mepc;
      csr_addr_mcause:    return m_mcause;
      csr_addr_mvendorid: return 32'h7973_7978;
      csr_addr_marchid:   return 32'h017D_9F58;
      default:            return '0;
    endcase
  endfunction

  always @(posedge clock) begin : model_update
    redirect_kind_t  kind;
    logic            fault;
    logic [xlen-1:0] cause;
    int              r;
    if (reset) begin
      for (int i = 0; i < gpr_count; i++) begin
        m_regs[i] = '0;
      end
      m_mstatus   = 32'h0000_1800;
      m_mtvec     = '0;
      m_mepc      = '0;
      m_mcause    = '0;
      m_npc       = '0;
      m_flush     = 1'b0;
      m_cache     = 1'b0;
      m_npc_valid = 1'b0;
    end else if (m_flush) begin
      m_flush     = 1'b0; // everything else ignored
      m_cache     = 1'b0;
      m_npc_valid = 1'b0;
    end else begin
      fault = inst_addr_misaligned | ecall | load_addr_misaligned | store_addr_misaligned;
      if (inst_addr_misaligned) cause = 32'd0;
      else if (ecall) cause = 32'd11;
      else if (load_addr_misaligned) cause = 32'd4;
      else cause = 32'd6;
      kind = fault ? redirect_trap : mret ? redirect_mret :
             (fence_i | wrong_prediction) ? redirect_flush : redirect_none;
      r = rd % gpr_count;
      if (wen && r != 0) m_regs[r] = wdata;
      case (kind) // old csr values
        redirect_trap: m_npc = m_mtvec;
        redirect_mret: m_npc = m_mepc;
        default:       m_npc = exu_npc;
      endcase
      if (fault) begin
        m_mepc   = lsu_pc;
        m_mcause = cause;
      end else if (csr_wen) begin
        if (csr_d == 12'h300) m_mstatus = csr_wdata;
        if (csr_d == 12'h305) m_mtvec = csr_wdata;
        if (csr_d == 12'h341) m_mepc = csr_wdata;
      end
      m_flush     = (kind != redirect_none);
      m_cache     = fence_i & ~fault;
      m_npc_valid = ls_valid;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic compare_value(input string what, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // sampled mid-cycle when inputs and outputs have settled
  always @(negedge clock) begin
    if (!reset) begin
      compare_value("src1", model_gpr(rs1), src1);
      compare_value("src2", model_gpr(rs2), src2);
      compare_value("csr_src", model_csr(csr_s), csr_src);
      compare_value("clear_pipeline", m_flush, clear_pipeline);
      compare_value("clear_cache", m_cache, clear_cache);
      compare_value("npc_valid", m_npc_valid, npc_valid);
      compare_value("npc", m_npc, npc);
    end
  end

  single_flush: assert property (@(posedge clock) disable iff (reset)
    clear_pipeline |=> !clear_pipeline)
    else begin
      error_count++;
      $display("clear_pipeline stayed high for more than one cycle");
    end

  flush_kills_npc: assert property (@(posedge clock) disable iff (reset)
    clear_pipeline |=> !npc_valid)
    else begin
      error_count++;
      $display("npc_valid was high right after a flush cycle");
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic clear_strobes();
    wen                   = 1'b0;
    csr_wen               = 1'b0;
    ls_valid              = 1'b0;
    inst_addr_misaligned  = 1'b0;
    ecall                 = 1'b0;
    load_addr_misaligned  = 1'b0;
    store_addr_misaligned = 1'b0;
    mret                  = 1'b0;
    fence_i               = 1'b0;
    wrong_prediction      = 1'b0;
  endtask

  task automatic random_reads();
    rs1   = $urandom % 32;
    rs2   = $urandom % 32;
    csr_s = csr_list[$urandom % 7];
  endtask

  initial begin
    void'($urandom(32'h5d64_8adb));
    error_count = 0;
    check_count = 0;
    test_name   = "reset";
    reset       = 1'b1;
    clear_strobes();
    rs1       = '0;
    rs2       = '0;
    rd        = '0;
    csr_s     = '0;
    csr_d     = '0;
    wdata     = '0;
    csr_wdata = '0;
    lsu_pc    = '0;
    exu_npc   = '0;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < 32; i++) begin
      rs1   = i;
      rs2   = 31 - i;
      csr_s = csr_list[i % 7];
      next_cycle();
    end

    test_name = "gpr";
    for (int i = 0; i < 150; i++) begin
      clear_strobes();
      random_reads();
      rs1              = rd; // last write target
      rd               = $urandom % 32;
      wen              = ($urandom % 4) != 0;
      wdata            = $urandom;
      exu_npc          = $urandom;
      wrong_prediction = ($urandom % 8) == 0;
      next_cycle();
    end

    test_name = "csr";
    clear_strobes();
    for (int i = 0; i < 15; i++) begin
      csr_wen   = 1'b1;
      csr_s     = csr_d;
      csr_d     = csr_list[i % 7];
      csr_wdata = $urandom;
      next_cycle();
    end

    test_name = "trap";
    for (int f = 1; f < 16; f++) begin
      clear_strobes();
      csr_s = csr_addr_mcause;
      {inst_addr_misaligned, ecall, load_addr_misaligned, store_addr_misaligned} = f[3:0];
      fence_i   = f[0];
      ls_valid  = 1'b1;
      lsu_pc    = $urandom;
      csr_wen   = 1'b1; // dropped by the trap
      csr_d     = csr_list[f % 3];
      csr_wdata = $urandom;
      next_cycle();
      clear_strobes();
      csr_s = csr_addr_mepc;
      next_cycle();
      csr_s = csr_addr_mcause;
      next_cycle();
    end

    test_name = "redirect";
    for (int i = 0; i < 60; i++) begin
      clear_strobes();
      random_reads();
      ls_valid = $urandom % 2;
      exu_npc  = $urandom;
      case ($urandom % 5)
        0: mret = 1'b1;
        1: fence_i = 1'b1;
        2: wrong_prediction = 1'b1;
        3: begin
          csr_wen   = 1'b1;
          csr_d     = csr_addr_mepc;
          csr_wdata = $urandom;
        end
        default: ;
      endcase
      next_cycle();
    end

    test_name = "flush";
    for (int i = 0; i < 10; i++) begin
      clear_strobes();
      wrong_prediction = 1'b1;
      exu_npc          = $urandom;
      next_cycle();
      // all of this lands in the flush cycle
      wen       = 1'b1;
      rd        = 1 + i;
      wdata     = $urandom;
      csr_wen   = 1'b1;
      csr_d     = csr_addr_mtvec;
      csr_wdata = $urandom;
      ecall     = i[0];
      mret      = ~i[0];
      fence_i   = 1'b1;
      ls_valid  = 1'b1;
      lsu_pc    = $urandom;
      next_cycle();
      clear_strobes();
      rs1   = rd;
      csr_s = i[0] ? csr_addr_mcause : csr_addr_mtvec;
      next_cycle();
    end

    clear_strobes();
    next_cycle();
    next_cycle();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((step_count + 50) * 10);
    $display("timeout: run did not end within %0d cycles, errors: %0d",
             step_count + 50, error_count);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- all.f
verilog/rv_csr_pkg.sv
verilog/commit_pkg.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/trap_redirect.sv
verilog/commit_unit.sv
sim/commit_unit_tb.sv

//--- Bender.yml
package:
  name: commit_unit

sources:
  - files:
      - verilog/rv_csr_pkg.sv
      - verilog/commit_pkg.sv
      - verilog/gpr_file.sv
      - verilog/csr_file.sv
      - verilog/trap_redirect.sv
      - verilog/commit_unit.sv
  - target: test
    files:
      - sim/commit_unit_tb.sv
